// File: sources.f
+incdir+hdl
hdl/image_pkg.sv
hdl/axi_pkg.sv
hdl/axi_write_port.sv
hdl/image_config_regs.sv
hdl/axi_read_port.sv
hdl/axi2fifo_top.sv
dv/tb_axi2fifo.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi2fifo
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_axi2fifo.sv
`timescale 1ns/1ps
`include "axi_image_macros.svh"

module tb_axi2fifo;

    localparam int NUM_ENTRIES  = 8;
    localparam int STALL_CYCLES = 6;
    localparam int BHOLD_CYCLES = 5;

    typedef enum logic [1:0] {OP_WRITE, OP_WRITE_FULL, OP_WRITE_BHOLD, OP_READ} op_e;

    // One table row
    // Beats is the W beat count or arlen+1
    typedef struct packed {
        logic [3:0]                       test_no;
        op_e                              op;
        logic [`AXI_ADDR_WIDTH-1:0]       addr;
        logic [`AXI_ID_WIDTH-1:0]         id;
        logic [7:0]                       beats;
        logic [3:0][`AXI_DATA_WIDTH-1:0]  data;
        logic [1:0]                       exp_resp;
        logic [`AXI_DATA_WIDTH-1:0]       exp_rdata;
        image_pkg::image_size_t           exp_size;
        image_pkg::test_window_t          exp_window;
    } entry_t;

    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]  id;
        logic [1:0]                resp;
    } b_beat_t;

    typedef struct packed {
        logic [`AXI_DATA_WIDTH-1:0]  data;
        logic [1:0]                  resp;
        logic                        last;
        logic [`AXI_ID_WIDTH-1:0]    id;
        logic [31:0]                 cyc;
    } r_beat_t;

    logic                          s_axi_aclk;
    logic                          s_axi_aresetn;
    logic [`AXI_ADDR_WIDTH-1:0]    s_axi_awaddr;
    logic [`AXI_ID_WIDTH-1:0]      s_axi_awid;
    logic                          s_axi_awvalid;
    logic                          s_axi_awready;
    logic [`AXI_DATA_WIDTH-1:0]    s_axi_wdata;
    logic [`AXI_DATA_WIDTH/8-1:0]  s_axi_wstrb;
    logic                          s_axi_wvalid;
    logic                          s_axi_wlast;
    logic                          s_axi_wready;
    logic                          s_axi_bready;
    logic [1:0]                    s_axi_bresp;
    logic                          s_axi_bvalid;
    logic [`AXI_ID_WIDTH-1:0]      s_axi_bid;
    logic [`AXI_ADDR_WIDTH-1:0]    s_axi_araddr;
    logic [`AXI_ID_WIDTH-1:0]      s_axi_arid;
    logic [7:0]                    s_axi_arlen;
    logic                          s_axi_arvalid;
    logic                          s_axi_arready;
    logic                          s_axi_rready;
    logic [`AXI_DATA_WIDTH-1:0]    s_axi_rdata;
    logic [1:0]                    s_axi_rresp;
    logic                          s_axi_rvalid;
    logic                          s_axi_rlast;
    logic [`AXI_ID_WIDTH-1:0]      s_axi_rid;
    logic                          image_sender_full;
    logic                          image_sender_reset;
    logic                          image_sender_flush;
    logic                          image_sender_write;
    logic [`AXI_DATA_WIDTH-1:0]    image_sender_fifo_din;
    logic [`IMG_WIDTH_BITS-1:0]    image_width;
    logic [`IMG_HEIGHT_BITS-1:0]   image_height;
    logic                          test_mode;
    logic [7:0]                    test_data;
    logic [`IMG_WIDTH_BITS-1:0]    test_start_x;
    logic [`IMG_HEIGHT_BITS-1:0]   test_start_y;
    logic [`IMG_WIDTH_BITS-1:0]    test_end_x;
    logic [`IMG_HEIGHT_BITS-1:0]   test_end_y;

    entry_t                      stim [NUM_ENTRIES];
    logic [`AXI_DATA_WIDTH-1:0]  fifo_q [$];
    b_beat_t                     b_q [$];
    r_beat_t                     r_q [$];
    logic [31:0]                 cycle = 32'd0;
    int                          checks = 0;
    int                          errors = 0;
    int                          errors_before;

    axi2fifo_top i_dut (.*);

    initial begin
        s_axi_aclk = 1'b0;
        forever #5 s_axi_aclk = ~s_axi_aclk;
    end

    // Bus monitor queues everything the DUT hands out
    always @(posedge s_axi_aclk) begin
        cycle = cycle + 32'd1;
        if (image_sender_write) begin
            fifo_q.push_back(image_sender_fifo_din);
        end
        if (s_axi_bvalid) begin
            b_q.push_back({s_axi_bid, s_axi_bresp});
        end
        if (s_axi_rvalid) begin
            r_q.push_back({s_axi_rdata, s_axi_rresp, s_axi_rlast, s_axi_rid, cycle});
        end
    end

    initial begin
        repeat (NUM_ENTRIES * 200) @(posedge s_axi_aclk);
        $display("Watchdog expired, the table did not complete in %0d cycles",
                 NUM_ENTRIES * 200);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [127:0] random_word();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    function automatic string op_label(input op_e op);
        case (op)
            OP_WRITE:       return "write";
            OP_WRITE_FULL:  return "write with sender full";
            OP_WRITE_BHOLD: return "write with BREADY held";
            default:        return "read";
        endcase
    endfunction

    ////////////////////
    // Stimulus table
    ////////////////////
    task automatic fill_table();
        image_pkg::image_size_t   size;
        image_pkg::test_window_t  win;
        logic [127:0]             word;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            stim[i] = '0;
        end
        // Plain FIFO burst and one against a full sender
        stim[0].test_no = 4'd1;
        stim[0].op      = OP_WRITE;
        stim[0].addr    = `ADDR_IMAGE_FIFO;
        stim[0].id      = 16'h1a2b;
        stim[0].beats   = 8'd4;
        stim[1].test_no = 4'd2;
        stim[1].op      = OP_WRITE_FULL;
        stim[1].addr    = `ADDR_IMAGE_FIFO;
        stim[1].id      = 16'h0c0d;
        stim[1].beats   = 8'd3;
        for (int b = 0; b < 4; b++) begin
            stim[0].data[b] = random_word();
            stim[1].data[b] = random_word();
        end
        // Size word with width at 43..32 and height at 10..0
        size.width  = 12'($urandom());
        size.height = 11'($urandom());
        word        = random_word();
        word[43:32] = size.width;
        word[10:0]  = size.height;
        stim[2].test_no  = 4'd3;
        stim[2].op       = OP_WRITE;
        stim[2].addr     = `ADDR_IMAGE_SIZE;
        stim[2].id       = 16'h0333;
        stim[2].beats    = 8'd1;
        stim[2].data[0]  = word;
        stim[2].exp_size = size;
        stim[3].test_no   = 4'd3;
        stim[3].op        = OP_READ;
        stim[3].addr      = `ADDR_RESOLUTION;
        stim[3].id        = 16'h4321;
        stim[3].beats     = 8'd3;
        stim[3].exp_rdata = {64'h0, 32'(size.width), 32'(size.height)};
        // Test window word with random padding around the fields
        win.mode    = 1'b1;
        win.data    = 8'($urandom());
        win.start_x = 12'($urandom());
        win.start_y = 11'($urandom());
        win.end_x   = 12'($urandom());
        win.end_y   = 11'($urandom());
        word        = random_word();
        word[63]    = win.mode;
        word[55:48] = win.data;
        word[47:36] = win.start_x;
        word[34:24] = win.start_y;
        word[23:12] = win.end_x;
        word[10:0]  = win.end_y;
        stim[4].test_no    = 4'd4;
        stim[4].op         = OP_WRITE;
        stim[4].addr       = `ADDR_SET_TEST;
        stim[4].id         = 16'h0444;
        stim[4].beats      = 8'd1;
        stim[4].data[0]    = word;
        stim[4].exp_size   = size;
        stim[4].exp_window = win;
        word    = random_word();
        word[0] = 1'b1;
        stim[5].test_no = 4'd5;
        stim[5].op      = OP_WRITE_BHOLD;
        stim[5].addr    = `ADDR_FLUSH;
        stim[5].id      = 16'h0555;
        stim[5].beats   = 8'd1;
        stim[5].data[0] = word;
        // Unknown offsets
        stim[6].test_no  = 4'd6;
        stim[6].op       = OP_WRITE;
        stim[6].addr     = 7'h40;
        stim[6].id       = 16'h0666;
        stim[6].exp_resp = `RESP_SLVERR;
        stim[7].test_no  = 4'd6;
        stim[7].op       = OP_READ;
        stim[7].addr     = 7'h30;
        stim[7].id       = 16'h0777;
        stim[7].beats    = 8'd1;
        stim[7].exp_resp = `RESP_SLVERR;
    endtask

    task automatic send_aw(input entry_t e);
        @(negedge s_axi_aclk);
        s_axi_awaddr  = e.addr;
        s_axi_awid    = e.id;
        s_axi_awvalid = 1'b1;
        @(posedge s_axi_aclk);
        while (!s_axi_awready) @(posedge s_axi_aclk);
        @(negedge s_axi_aclk);
        s_axi_awvalid = 1'b0;
        // Port has left idle
        check_value("s_axi_awready", 128'(s_axi_awready), 128'(1'b0));
    endtask

    task automatic send_w(input entry_t e, input bit stall);
        int nbeats;
        nbeats = int'(e.beats);
        for (int b = 0; b < nbeats; b++) begin
            @(negedge s_axi_aclk);
            s_axi_wdata  = e.data[b];
            s_axi_wlast  = (b == nbeats - 1);
            s_axi_wvalid = 1'b1;
            if (stall && b == 0) begin
                repeat (STALL_CYCLES) begin
                    @(posedge s_axi_aclk);
                    check_value("s_axi_wready", 128'(s_axi_wready), 128'(1'b0));
                end
                @(negedge s_axi_aclk);
                check_value("image_sender_write pulse count", 128'(fifo_q.size()), 128'(0));
                image_sender_full = 1'b0;
            end
            @(posedge s_axi_aclk);
            while (!s_axi_wready) @(posedge s_axi_aclk);
        end
        @(negedge s_axi_aclk);
        s_axi_wvalid = 1'b0;
        s_axi_wlast  = 1'b0;
    endtask

    task automatic run_write(input entry_t e);
        b_beat_t beat;
        int      nbeats;
        nbeats = int'(e.beats);
        @(negedge s_axi_aclk);
        image_sender_full = (e.op == OP_WRITE_FULL);
        s_axi_bready      = (e.op != OP_WRITE_BHOLD);
        send_aw(e);
        send_w(e, e.op == OP_WRITE_FULL);
        if (e.op == OP_WRITE_BHOLD) begin
            repeat (BHOLD_CYCLES) begin
                @(negedge s_axi_aclk);
                check_value("s_axi_bvalid count", 128'(b_q.size()), 128'(0));
                check_value("image_sender_flush", 128'(image_sender_flush), 128'(1'b1));
            end
            s_axi_bready = 1'b1;
        end
        while (b_q.size() == 0) @(negedge s_axi_aclk);
        beat = b_q.pop_front();
        check_value("s_axi_bresp", 128'(beat.resp), 128'(e.exp_resp));
        check_value("s_axi_bid", 128'(beat.id), 128'(e.id));
        repeat (3) @(negedge s_axi_aclk);
        check_value("s_axi_bvalid count", 128'(b_q.size()), 128'(0));
        check_value("s_axi_awready", 128'(s_axi_awready), 128'(1'b1));
        if (e.addr == `ADDR_IMAGE_FIFO) begin
            check_value("image_sender_write pulse count", 128'(fifo_q.size()), 128'(nbeats));
            for (int b = 0; b < nbeats && fifo_q.size() > 0; b++) begin
                check_value("image_sender_fifo_din", fifo_q.pop_front(), e.data[b]);
            end
        end else begin
            check_value("image_sender_write pulse count", 128'(fifo_q.size()), 128'(0));
        end
        if (e.addr == `ADDR_IMAGE_SIZE || e.addr == `ADDR_SET_TEST) begin
            check_value("image_width", 128'(image_width), 128'(e.exp_size.width));
            check_value("image_height", 128'(image_height), 128'(e.exp_size.height));
        end
        if (e.addr == `ADDR_SET_TEST) begin
            check_value("test_mode", 128'(test_mode), 128'(e.exp_window.mode));
            check_value("test_data", 128'(test_data), 128'(e.exp_window.data));
            check_value("test_start_x", 128'(test_start_x), 128'(e.exp_window.start_x));
            check_value("test_start_y", 128'(test_start_y), 128'(e.exp_window.start_y));
            check_value("test_end_x", 128'(test_end_x), 128'(e.exp_window.end_x));
            check_value("test_end_y", 128'(test_end_y), 128'(e.exp_window.end_y));
        end
        // Flush falls once the port is back in idle
        if (e.addr == `ADDR_FLUSH) begin
            check_value("image_sender_flush", 128'(image_sender_flush), 128'(1'b0));
        end
        fifo_q.delete();
        b_q.delete();
    endtask

    task automatic run_read(input entry_t e);
        r_beat_t      beat;
        logic [31:0]  ar_cyc;
        int           nbeats;
        nbeats = int'(e.beats);
        @(negedge s_axi_aclk);
        s_axi_araddr  = e.addr;
        s_axi_arid    = e.id;
        s_axi_arlen   = e.beats - 8'd1;
        s_axi_arvalid = 1'b1;
        @(posedge s_axi_aclk);
        while (!s_axi_arready) @(posedge s_axi_aclk);
        @(negedge s_axi_aclk);
        s_axi_arvalid = 1'b0;
        ar_cyc        = cycle;
        check_value("s_axi_arready", 128'(s_axi_arready), 128'(1'b0));
        while (r_q.size() < nbeats) @(negedge s_axi_aclk);
        repeat (3) @(negedge s_axi_aclk);
        check_value("s_axi_rvalid beat count", 128'(r_q.size()), 128'(nbeats));
        check_value("s_axi_arready", 128'(s_axi_arready), 128'(1'b1));
        for (int i = 0; i < nbeats; i++) begin
            beat = r_q.pop_front();
            check_value("s_axi_rdata", beat.data, e.exp_rdata);
            check_value("s_axi_rresp", 128'(beat.resp), 128'(e.exp_resp));
            check_value("s_axi_rid", 128'(beat.id), 128'(e.id));
            check_value("s_axi_rlast", 128'(beat.last), 128'(i == nbeats - 1));
            // First beat one cycle after the AR handshake and then back to back
            check_value("s_axi_rvalid beat timing", 128'(beat.cyc - ar_cyc), 128'(i + 2));
        end
        r_q.delete();
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        void'($urandom(32'hfd8));
        s_axi_aresetn     = 1'b0;
        s_axi_awaddr      = '0;
        s_axi_awid        = '0;
        s_axi_awvalid     = 1'b0;
        s_axi_wdata       = '0;
        s_axi_wstrb       = '1;
        s_axi_wvalid      = 1'b0;
        s_axi_wlast       = 1'b0;
        s_axi_bready      = 1'b1;
        s_axi_araddr      = '0;
        s_axi_arid        = '0;
        s_axi_arlen       = '0;
        s_axi_arvalid     = 1'b0;
        s_axi_rready      = 1'b1;
        image_sender_full = 1'b0;
        fill_table();
        repeat (4) @(posedge s_axi_aclk);
        @(negedge s_axi_aclk);
        errors_before = errors;
        check_value("image_sender_reset", 128'(image_sender_reset), 128'(1'b1));
        check_value("s_axi_bvalid", 128'(s_axi_bvalid), 128'(1'b0));
        check_value("s_axi_rvalid", 128'(s_axi_rvalid), 128'(1'b0));
        check_value("s_axi_rlast", 128'(s_axi_rlast), 128'(1'b0));
        check_value("image_sender_write", 128'(image_sender_write), 128'(1'b0));
        check_value("image_sender_flush", 128'(image_sender_flush), 128'(1'b0));
        check_value("image_width", 128'(image_width), 128'(0));
        s_axi_aresetn = 1'b1;
        @(negedge s_axi_aclk);
        check_value("image_sender_reset", 128'(image_sender_reset), 128'(1'b0));
        $display("reset: %s", (errors == errors_before) ? "ok" : "errors");
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            errors_before = errors;
            if (stim[i].op == OP_READ) begin
                run_read(stim[i]);
            end else begin
                run_write(stim[i]);
            end
            $display("test %0d, entry %0d, %s at 0x%02h: %s", stim[i].test_no, i,
                     op_label(stim[i].op), stim[i].addr,
                     (errors == errors_before) ? "ok" : "errors");
        end
        $display("entries %0d, checks %0d, errors %0d", NUM_ENTRIES, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: hdl/axi2fifo_top.sv
`timescale 1ns/1ps
`include "axi_image_macros.svh"

module axi2fifo_top (
    input  logic                          s_axi_aclk,
    input  logic                          s_axi_aresetn,
    input  logic [`AXI_ADDR_WIDTH-1:0]    s_axi_awaddr,
    input  logic [`AXI_ID_WIDTH-1:0]      s_axi_awid,
    input  logic                          s_axi_awvalid,
    output logic                          s_axi_awready,
    input  logic [`AXI_DATA_WIDTH-1:0]    s_axi_wdata,
    input  logic [`AXI_DATA_WIDTH/8-1:0]  s_axi_wstrb,
    input  logic                          s_axi_wvalid,
    input  logic                          s_axi_wlast,
    output logic                          s_axi_wready,
    input  logic                          s_axi_bready,
    output logic [1:0]                    s_axi_bresp,
    output logic                          s_axi_bvalid,
    output logic [`AXI_ID_WIDTH-1:0]      s_axi_bid,
    input  logic [`AXI_ADDR_WIDTH-1:0]    s_axi_araddr,
    input  logic [`AXI_ID_WIDTH-1:0]      s_axi_arid,
    input  logic [7:0]                    s_axi_arlen,
    input  logic                          s_axi_arvalid,
    output logic                          s_axi_arready,
    input  logic                          s_axi_rready,
    output logic [`AXI_DATA_WIDTH-1:0]    s_axi_rdata,
    output logic [1:0]                    s_axi_rresp,
    output logic                          s_axi_rvalid,
    output logic                          s_axi_rlast,
    output logic [`AXI_ID_WIDTH-1:0]      s_axi_rid,
    input  logic                          image_sender_full,
    output logic                          image_sender_reset,
    output logic                          image_sender_flush,
    output logic                          image_sender_write,
    output logic [`AXI_DATA_WIDTH-1:0]    image_sender_fifo_din,
    output logic [`IMG_WIDTH_BITS-1:0]    image_width,
    output logic [`IMG_HEIGHT_BITS-1:0]   image_height,
    output logic                          test_mode,
    output logic [7:0]                    test_data,
    output logic [`IMG_WIDTH_BITS-1:0]    test_start_x,
    output logic [`IMG_HEIGHT_BITS-1:0]   test_start_y,
    output logic [`IMG_WIDTH_BITS-1:0]    test_end_x,
    output logic [`IMG_HEIGHT_BITS-1:0]   test_end_y
);

    axi_pkg::reg_beat_t       reg_beat;
    logic                     write_idle;
    image_pkg::image_size_t   image_size;
    image_pkg::test_window_t  test_window;

    // Sender is held in reset with the bus
    assign image_sender_reset = ~s_axi_aresetn;

    ////////////////////
    // Sender side outputs
    ////////////////////
    assign image_width  = image_size.width;
    assign image_height = image_size.height;
    assign test_mode    = test_window.mode;
    assign test_data    = test_window.data;
    assign test_start_x = test_window.start_x;
    assign test_start_y = test_window.start_y;
    assign test_end_x   = test_window.end_x;
    assign test_end_y   = test_window.end_y;

    axi_write_port i_write_port (
        .s_axi_aclk            (s_axi_aclk),
        .s_axi_aresetn         (s_axi_aresetn),
        .s_axi_awaddr          (s_axi_awaddr),
        .s_axi_awid            (s_axi_awid),
        .s_axi_awvalid         (s_axi_awvalid),
        .s_axi_awready         (s_axi_awready),
        .s_axi_wdata           (s_axi_wdata),
        .s_axi_wvalid          (s_axi_wvalid),
        .s_axi_wlast           (s_axi_wlast),
        .s_axi_wready          (s_axi_wready),
        .s_axi_bready          (s_axi_bready),
        .s_axi_bresp           (s_axi_bresp),
        .s_axi_bvalid          (s_axi_bvalid),
        .s_axi_bid             (s_axi_bid),
        .image_sender_full     (image_sender_full),
        .image_sender_write    (image_sender_write),
        .image_sender_fifo_din (image_sender_fifo_din),
        .reg_beat              (reg_beat),
        .write_idle            (write_idle)
    );

    image_config_regs i_config_regs (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .reg_beat      (reg_beat),
        .write_idle    (write_idle),
        .flush         (image_sender_flush),
        .image_size    (image_size),
        .test_window   (test_window)
    );

    axi_read_port i_read_port (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arid    (s_axi_arid),
        .s_axi_arlen   (s_axi_arlen),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rlast   (s_axi_rlast),
        .s_axi_rid     (s_axi_rid),
        .image_size    (image_size)
    );

endmodule

// File: hdl/axi_read_port.sv
`timescale 1ns/1ps
`include "axi_image_macros.svh"

module axi_read_port (
    input  logic                        s_axi_aclk,
    input  logic                        s_axi_aresetn,
    input  logic [`AXI_ADDR_WIDTH-1:0]  s_axi_araddr,
    input  logic [`AXI_ID_WIDTH-1:0]    s_axi_arid,
    input  logic [7:0]                  s_axi_arlen,
    input  logic                        s_axi_arvalid,
    output logic                        s_axi_arready,
    output logic [`AXI_DATA_WIDTH-1:0]  s_axi_rdata,
    output logic [1:0]                  s_axi_rresp,
    output logic                        s_axi_rvalid,
    output logic                        s_axi_rlast,
    output logic [`AXI_ID_WIDTH-1:0]    s_axi_rid,
    input  image_pkg::image_size_t      image_size
);

    typedef enum logic [1:0] {ST_IDLE, ST_RES, ST_ERR} state_e;

    state_e                    state;
    logic [7:0]                beats_left;
    logic [`AXI_ID_WIDTH-1:0]  arid_q;
    logic                      last_beat;

    assign s_axi_arready = (state == ST_IDLE);
    assign last_beat     = (beats_left == 8'd0);

    ////////////////////
    // AR/R FSM
    ////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state        <= ST_IDLE;
            beats_left   <= 8'd0;
            s_axi_rvalid <= 1'b0;
            s_axi_rlast  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    s_axi_rvalid <= 1'b0;
                    s_axi_rlast  <= 1'b0;
                    if (s_axi_arvalid) begin
                        beats_left <= s_axi_arlen;
                        state <= (s_axi_araddr == `ADDR_RESOLUTION) ? ST_RES : ST_ERR;
                    end
                end
                ST_RES: begin
                    // One beat per cycle, RREADY is not looked at
                    s_axi_rvalid <= 1'b1;
                    s_axi_rlast  <= last_beat;
                    beats_left   <= beats_left - 8'd1;
                    if (last_beat) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    s_axi_rvalid <= 1'b1;
                    s_axi_rlast  <= 1'b1;
                    state        <= ST_IDLE;
                end
            endcase
        end
    end

    // Beat contents and echoed id
    always_ff @(posedge s_axi_aclk) begin
        if (s_axi_arvalid && s_axi_arready) begin
            arid_q <= s_axi_arid;
        end
        if (state == ST_RES) begin
            s_axi_rdata <= {{(`AXI_DATA_WIDTH-64){1'b0}},
                            32'(image_size.width), 32'(image_size.height)};
            s_axi_rresp <= `RESP_OKAY;
            s_axi_rid   <= arid_q;
        end else if (state == ST_ERR) begin
            s_axi_rdata <= '0;
            s_axi_rresp <= `RESP_SLVERR;
            s_axi_rid   <= arid_q;
        end
    end

endmodule

// File: hdl/image_config_regs.sv
`timescale 1ns/1ps
`include "axi_image_macros.svh"

module image_config_regs (
    input  logic                    s_axi_aclk,
    input  logic                    s_axi_aresetn,
    input  axi_pkg::reg_beat_t      reg_beat,
    input  logic                    write_idle,
    output logic                    flush,
    output image_pkg::image_size_t  image_size,
    output image_pkg::test_window_t test_window
);

    ////////////////////
    // Register update
    ////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            flush       <= 1'b0;
            image_size  <= '0;
            test_window <= '0;
        end else begin
            // Flush level drops once the write burst has been answered
            if (write_idle) begin
                flush <= 1'b0;
            end
            if (reg_beat.valid) begin
                case (reg_beat.target)
                    axi_pkg::TGT_FLUSH: begin
                        if (reg_beat.data[0]) begin
                            flush <= 1'b1;
                        end
                    end
                    axi_pkg::TGT_SIZE: begin
                        image_size.width  <= reg_beat.data.size.width;
                        image_size.height <= reg_beat.data.size.height;
                    end
                    axi_pkg::TGT_TEST: begin
                        // Only the closing beat of the burst counts
                        if (reg_beat.last) begin
                            test_window.mode    <= reg_beat.data.test.mode;
                            test_window.data    <= reg_beat.data.test.data;
                            test_window.start_x <= reg_beat.data.test.start_x;
                            test_window.start_y <= reg_beat.data.test.start_y;
                            test_window.end_x   <= reg_beat.data.test.end_x;
                            test_window.end_y   <= reg_beat.data.test.end_y;
                        end
                    end
                    default: begin
                        // FIFO beats go to the sender
                    end
                endcase
            end
        end
    end

endmodule

// File: hdl/axi_write_port.sv
`timescale 1ns/1ps
`include "axi_image_macros.svh"

module axi_write_port (
    input  logic                        s_axi_aclk,
    input  logic                        s_axi_aresetn,
    input  logic [`AXI_ADDR_WIDTH-1:0]  s_axi_awaddr,
    input  logic [`AXI_ID_WIDTH-1:0]    s_axi_awid,
    input  logic                        s_axi_awvalid,
    output logic                        s_axi_awready,
    input  logic [`AXI_DATA_WIDTH-1:0]  s_axi_wdata,
    input  logic                        s_axi_wvalid,
    input  logic                        s_axi_wlast,
    output logic                        s_axi_wready,
    input  logic                        s_axi_bready,
    output logic [1:0]                  s_axi_bresp,
    output logic                        s_axi_bvalid,
    output logic [`AXI_ID_WIDTH-1:0]    s_axi_bid,
    input  logic                        image_sender_full,
    output logic                        image_sender_write,
    output logic [`AXI_DATA_WIDTH-1:0]  image_sender_fifo_din,
    output axi_pkg::reg_beat_t          reg_beat,
    output logic                        write_idle
);

    typedef enum logic [1:0] {ST_IDLE, ST_DATA, ST_ERROR, ST_RESP} state_e;

    state_e                  state;
    axi_pkg::aw_cmd_t        cmd;
    axi_pkg::write_target_e  aw_target;
    logic                    w_fire;
    logic                    fifo_beat;
    logic                    b_issue;

    // Offset decode
    always_comb begin
        case (s_axi_awaddr)
            `ADDR_IMAGE_FIFO: aw_target = axi_pkg::TGT_FIFO;
            `ADDR_FLUSH:      aw_target = axi_pkg::TGT_FLUSH;
            `ADDR_IMAGE_SIZE: aw_target = axi_pkg::TGT_SIZE;
            `ADDR_SET_TEST:   aw_target = axi_pkg::TGT_TEST;
            default:          aw_target = axi_pkg::TGT_ERROR;
        endcase
    end

    assign s_axi_awready = (state == ST_IDLE);
    assign write_idle    = (state == ST_IDLE);

    // FIFO bursts stall on full, register bursts never do
    assign s_axi_wready = (state == ST_DATA)
                          && !((cmd.target == axi_pkg::TGT_FIFO) && image_sender_full);
    assign w_fire    = s_axi_wvalid && s_axi_wready;
    assign fifo_beat = w_fire && (cmd.target == axi_pkg::TGT_FIFO);
    assign b_issue   = ((state == ST_ERROR) || (state == ST_RESP)) && s_axi_bready;

    always_comb begin
        reg_beat.valid  = w_fire && (cmd.target != axi_pkg::TGT_FIFO);
        reg_beat.target = cmd.target;
        reg_beat.last   = s_axi_wlast;
        reg_beat.data   = image_pkg::reg_word_u'(s_axi_wdata);
    end

    ////////////////////
    // AW/W/B FSM
    ////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state              <= ST_IDLE;
            cmd.target         <= axi_pkg::TGT_FIFO;
            s_axi_bvalid       <= 1'b0;
            image_sender_write <= 1'b0;
        end else begin
            s_axi_bvalid       <= b_issue;
            image_sender_write <= fifo_beat;
            case (state)
                ST_IDLE: begin
                    if (s_axi_awvalid) begin
                        cmd.target <= aw_target;
                        // No W beats taken for an unknown offset
                        state <= (aw_target == axi_pkg::TGT_ERROR) ? ST_ERROR : ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (w_fire && s_axi_wlast) begin
                        state <= ST_RESP;
                    end
                end
                default: begin
                    if (b_issue) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Beat data, id and response code
    always_ff @(posedge s_axi_aclk) begin
        if (s_axi_awvalid && s_axi_awready) begin
            cmd.id <= s_axi_awid;
        end
        if (fifo_beat) begin
            image_sender_fifo_din <= s_axi_wdata;
        end
        if (b_issue) begin
            s_axi_bid   <= cmd.id;
            s_axi_bresp <= (state == ST_ERROR) ? `RESP_SLVERR : `RESP_OKAY;
        end
    end

endmodule

// File: hdl/axi_pkg.sv
`include "axi_image_macros.svh"

package axi_pkg;

    ////////////////////
    // Write side types
    ////////////////////

    // Where the W beats of a burst go
    typedef enum logic [2:0] {
        TGT_FIFO,
        TGT_FLUSH,
        TGT_SIZE,
        TGT_TEST,
        TGT_ERROR
    } write_target_e;

    // Held from the AW handshake until the B response
    typedef struct packed {
        write_target_e             target;
        logic [`AXI_ID_WIDTH-1:0]  id;
    } aw_cmd_t;

    // One accepted W beat for the configuration registers
    typedef struct packed {
        logic                   valid;
        write_target_e          target;
        logic                   last;
        image_pkg::reg_word_u   data;
    } reg_beat_t;

endpackage

// File: hdl/image_pkg.sv
`include "axi_image_macros.svh"

package image_pkg;

    typedef struct packed {
        logic [`IMG_WIDTH_BITS-1:0]   width;
        logic [`IMG_HEIGHT_BITS-1:0]  height;
    } image_size_t;

    // Test pattern window, corners in pixels
    typedef struct packed {
        logic                         mode;
        logic [7:0]                   data;
        logic [`IMG_WIDTH_BITS-1:0]   start_x;
        logic [`IMG_HEIGHT_BITS-1:0]  start_y;
        logic [`IMG_WIDTH_BITS-1:0]   end_x;
        logic [`IMG_HEIGHT_BITS-1:0]  end_y;
    } test_window_t;

    ////////////////////
    // W data word views
    ////////////////////

    // Size write: width at 43..32, height at 10..0
    typedef struct packed {
        logic [`AXI_DATA_WIDTH-45:0]  pad_hi;
        logic [`IMG_WIDTH_BITS-1:0]   width;
        logic [20:0]                  pad_mid;
        logic [`IMG_HEIGHT_BITS-1:0]  height;
    } size_view_t;

    // Test window write, fields packed below bit 64
    typedef struct packed {
        logic [`AXI_DATA_WIDTH-65:0]  pad_hi;
        logic                         mode;
        logic [6:0]                   pad_mode;
        logic [7:0]                   data;
        logic [`IMG_WIDTH_BITS-1:0]   start_x;
        logic                         pad_sy;
        logic [`IMG_HEIGHT_BITS-1:0]  start_y;
        logic [`IMG_WIDTH_BITS-1:0]   end_x;
        logic                         pad_ey;
        logic [`IMG_HEIGHT_BITS-1:0]  end_y;
    } test_view_t;

    typedef union packed {
        size_view_t  size;
        test_view_t  test;
    } reg_word_u;

endpackage

// File: hdl/axi_image_macros.svh
`ifndef AXI_IMAGE_MACROS_SVH
`define AXI_IMAGE_MACROS_SVH

////////////////////
// Bus field widths
////////////////////
`define AXI_ADDR_WIDTH 7
`define AXI_DATA_WIDTH 128
`define AXI_ID_WIDTH 16

// Pixel coordinate sizes
`define IMG_WIDTH_BITS 12
`define IMG_HEIGHT_BITS 11

////////////////////
// Write offsets
////////////////////
`define ADDR_IMAGE_FIFO 7'h00
`define ADDR_FLUSH 7'h10
`define ADDR_IMAGE_SIZE 7'h20
`define ADDR_SET_TEST 7'h70

// Read offset
`define ADDR_RESOLUTION 7'h10

// Response codes
`define RESP_OKAY 2'b00
`define RESP_SLVERR 2'b10

`endif
